// File: design/mem_stream_pkg.sv
package mem_stream_pkg;

  // Buffer geometry, one byte per location
  localparam int MEM_DEPTH = 512;
  localparam int ADDR_W = 9;  // log2 of MEM_DEPTH

  // Data widths that carry a meaning
  typedef logic [7:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [7:0] len_t;  // Byte count minus one

  // First byte of every OUT packet
  localparam byte_t CMD_WRITE = 8'h01;
  localparam byte_t CMD_READ = 8'h02;

  // One stream beat, always a whole byte, so no tkeep
  typedef struct packed {
    logic  tlast;
    byte_t tdata;
  } stream_beat_t;

  // One memory access as seen by the arbiter and the bank
  typedef struct packed {
    logic  we;     // Write when set, read otherwise
    addr_t addr;
    byte_t wdata;
  } mem_req_t;

endpackage

// File: design/sram_bank.sv
module sram_bank (
  input  logic                     bus_clock_i,
  input  logic                     en_i,
  input  mem_stream_pkg::mem_req_t cmd_i,
  output mem_stream_pkg::byte_t    rdata_o
);
  import mem_stream_pkg::*;

  byte_t mem_q [MEM_DEPTH];

  // Block RAM style port, read-before-write on the same address
  always_ff @(posedge bus_clock_i) begin
    if (en_i) begin
      if (cmd_i.we) begin
        mem_q[cmd_i.addr] <= cmd_i.wdata;
      end
      rdata_o <= mem_q[cmd_i.addr];  // Valid the cycle after en_i
    end
  end

endmodule

// File: design/mem_arbiter.sv
module mem_arbiter (
  input  logic                           bus_clock_i,
  input  logic                           arst_n_i,
  input  logic [1:0]                     req_i,
  input  mem_stream_pkg::mem_req_t [1:0] cmd_i,
  output logic [1:0]                     ack_o,
  output mem_stream_pkg::byte_t          rdata_o,
  output logic                           bank_en_o,
  output mem_stream_pkg::mem_req_t       bank_cmd_o,
  input  mem_stream_pkg::byte_t          bank_rdata_i
);
  import mem_stream_pkg::*;

  typedef enum logic [1:0] {
    A_IDLE,
    A_ACCESS,
    A_ACK,
    A_RELEASE
  } arb_state_t;

  arb_state_t state_q;
  logic       grant_q;  // Engine being served
  logic       last_q;   // Engine served most recently
  logic       pick;
  byte_t      rdata_q;

  // On contention the engine not served last wins
  always_comb begin
    if (req_i[0] && req_i[1]) begin
      pick = ~last_q;
    end else begin
      pick = req_i[1];
    end
  end

  always_ff @(posedge bus_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= A_IDLE;
      grant_q <= 1'b0;
      last_q  <= 1'b1;  // Engine 0 goes first
      ack_o   <= '0;
    end else begin
      case (state_q)
        A_IDLE: begin
          if (|req_i) begin
            grant_q <= pick;
            last_q  <= pick;
            state_q <= A_ACCESS;
          end
        end
        A_ACCESS: state_q <= A_ACK;  // Bank enabled for this one cycle
        A_ACK: begin
          if (ack_o == '0) begin
            ack_o[grant_q] <= 1'b1;
          end else if (!req_i[grant_q]) begin
            ack_o   <= '0;
            state_q <= A_RELEASE;
          end
        end
        A_RELEASE: state_q <= A_IDLE;
        default:   state_q <= A_IDLE;
      endcase
    end
  end

  // Bank output is latched as the ack rises and held through the handshake
  always_ff @(posedge bus_clock_i) begin
    if (state_q == A_ACK && ack_o == '0) begin
      rdata_q <= bank_rdata_i;
    end
  end

  assign bank_en_o  = (state_q == A_ACCESS);
  assign bank_cmd_o = cmd_i[grant_q];
  assign rdata_o    = rdata_q;

  a_ack_onehot : assert property (@(posedge bus_clock_i) disable iff (!arst_n_i)
    $onehot0(ack_o))
    else $error("mem_arbiter: more than one engine acknowledged");

  // The ack may outlive its request by the single cycle the drop takes to be seen
  for (genvar gi = 0; gi < 2; gi++) begin : g_ack_chk
    a_ack_follows_req : assert property (@(posedge bus_clock_i) disable iff (!arst_n_i)
      ack_o[gi] |-> (req_i[gi] || $past(req_i[gi])))
      else $error("mem_arbiter: ack %0d without request", gi);
  end

endmodule

// File: design/stream_cmd_engine.sv
module stream_cmd_engine (
  input  logic                         bus_clock_i,
  input  logic                         arst_n_i,
  input  logic                         out_valid_i,
  input  mem_stream_pkg::stream_beat_t out_beat_i,
  output logic                         out_ready_o,
  output logic                         in_valid_o,
  output mem_stream_pkg::stream_beat_t in_beat_o,
  input  logic                         in_ready_i,
  output logic                         mem_req_o,
  output mem_stream_pkg::mem_req_t     mem_cmd_o,
  input  logic                         mem_ack_i,
  input  mem_stream_pkg::byte_t        mem_rdata_i
);
  import mem_stream_pkg::*;

  typedef enum logic [3:0] {
    S_CMD,
    S_ADDR_HI,
    S_ADDR_LO,
    S_LEN,
    S_WDATA,
    S_MEM_REQ,
    S_MEM_DROP,
    S_SEND,
    S_DISCARD
  } eng_state_t;

  eng_state_t state_q;
  eng_state_t state_d;
  logic       is_wr_q;   // Current packet is a write
  logic       last_q;    // Write byte in flight carried tlast
  addr_t      addr_q;    // Running buffer address
  addr_t      addr_next;
  len_t       len_q;     // Read bytes left minus one
  byte_t      wdata_q;
  byte_t      rdata_q;
  logic       take;      // OUT beat accepted this cycle
  logic       send_done; // IN beat accepted this cycle

  assign take      = out_valid_i && out_ready_o;
  assign send_done = in_valid_o && in_ready_i;
  assign addr_next = (addr_q == addr_t'(MEM_DEPTH - 1)) ? '0 : addr_q + 1'b1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_CMD: begin
        if (take) begin
          if (out_beat_i.tlast) begin
            state_d = S_CMD;  // One-byte packet, nothing to do
          end else if (out_beat_i.tdata == CMD_WRITE || out_beat_i.tdata == CMD_READ) begin
            state_d = S_ADDR_HI;
          end else begin
            state_d = S_DISCARD;
          end
        end
      end
      S_ADDR_HI: begin
        if (take) begin
          state_d = out_beat_i.tlast ? S_CMD : S_ADDR_LO;
        end
      end
      S_ADDR_LO: begin
        if (take) begin
          if (out_beat_i.tlast) begin
            state_d = S_CMD;
          end else begin
            state_d = is_wr_q ? S_WDATA : S_LEN;
          end
        end
      end
      // A read must end exactly on its length byte
      S_LEN: begin
        if (take) begin
          state_d = out_beat_i.tlast ? S_MEM_REQ : S_DISCARD;
        end
      end
      S_WDATA: begin
        if (take) begin
          state_d = S_MEM_REQ;
        end
      end
      S_MEM_REQ: begin
        if (mem_ack_i) begin
          state_d = S_MEM_DROP;
        end
      end
      S_MEM_DROP: begin
        if (!mem_ack_i) begin
          if (!is_wr_q) begin
            state_d = S_SEND;
          end else begin
            state_d = last_q ? S_CMD : S_WDATA;
          end
        end
      end
      S_SEND: begin
        if (send_done) begin
          state_d = (len_q == '0) ? S_CMD : S_MEM_REQ;
        end
      end
      S_DISCARD: begin
        if (take && out_beat_i.tlast) begin
          state_d = S_CMD;
        end
      end
      default: state_d = S_CMD;
    endcase
  end

  // Handshake outputs are registered from the next state
  always_ff @(posedge bus_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= S_CMD;
      out_ready_o <= 1'b0;
      in_valid_o  <= 1'b0;
      mem_req_o   <= 1'b0;
      is_wr_q     <= 1'b0;
      last_q      <= 1'b0;
      addr_q      <= '0;
      len_q       <= '0;
    end else begin
      state_q     <= state_d;
      out_ready_o <= state_d inside {S_CMD, S_ADDR_HI, S_ADDR_LO, S_LEN, S_WDATA, S_DISCARD};
      in_valid_o  <= (state_d == S_SEND);
      mem_req_o   <= (state_d == S_MEM_REQ);
      if (take) begin
        case (state_q)
          S_CMD:     is_wr_q <= (out_beat_i.tdata == CMD_WRITE);
          S_ADDR_HI: addr_q <= addr_t'({out_beat_i.tdata, 8'h00});  // Upper bits dropped
          S_ADDR_LO: addr_q[7:0] <= out_beat_i.tdata;
          S_LEN:     len_q <= len_t'(out_beat_i.tdata);
          S_WDATA:   last_q <= out_beat_i.tlast;
          default:   ;
        endcase
      end
      if (state_q == S_MEM_DROP && !mem_ack_i && is_wr_q) begin
        addr_q <= addr_next;  // Next payload byte
      end
      if (send_done && len_q != '0) begin
        len_q  <= len_q - 1'b1;
        addr_q <= addr_next;
      end
    end
  end

  always_ff @(posedge bus_clock_i) begin
    if (take && state_q == S_WDATA) begin
      wdata_q <= out_beat_i.tdata;
    end
    if (state_q == S_MEM_REQ && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_cmd_o = '{we: is_wr_q, addr: addr_q, wdata: wdata_q};
  assign in_beat_o = '{tlast: (len_q == '0), tdata: rdata_q};

  a_in_hold : assert property (@(posedge bus_clock_i) disable iff (!arst_n_i)
    in_valid_o && !in_ready_i |=> in_valid_o && $stable(in_beat_o))
    else $error("stream_cmd_engine: IN beat changed under back-pressure");

  a_cmd_hold : assert property (@(posedge bus_clock_i) disable iff (!arst_n_i)
    mem_req_o |=> !mem_req_o || $stable(mem_cmd_o))
    else $error("stream_cmd_engine: memory command changed during request");

endmodule

// File: design/mem_stream_top.sv
module mem_stream_top (
  input  logic                               bus_clock_i,
  input  logic                               arst_n_i,
  input  logic [1:0]                         out_valid_i,
  input  mem_stream_pkg::stream_beat_t [1:0] out_beat_i,
  output logic [1:0]                         out_ready_o,
  output logic [1:0]                         in_valid_o,
  output mem_stream_pkg::stream_beat_t [1:0] in_beat_o,
  input  logic [1:0]                         in_ready_i
);
  import mem_stream_pkg::*;

  logic [1:0]     mem_req;
  mem_req_t [1:0] mem_cmd;
  logic [1:0]     mem_ack;
  byte_t          mem_rdata;  // Shared, only the acked engine samples it
  logic           bank_en;
  mem_req_t       bank_cmd;
  byte_t          bank_rdata;

  stream_cmd_engine u_engine0 (
    .bus_clock_i(bus_clock_i),
    .arst_n_i   (arst_n_i),
    .out_valid_i(out_valid_i[0]),
    .out_beat_i (out_beat_i[0]),
    .out_ready_o(out_ready_o[0]),
    .in_valid_o (in_valid_o[0]),
    .in_beat_o  (in_beat_o[0]),
    .in_ready_i (in_ready_i[0]),
    .mem_req_o  (mem_req[0]),
    .mem_cmd_o  (mem_cmd[0]),
    .mem_ack_i  (mem_ack[0]),
    .mem_rdata_i(mem_rdata)
  );

  stream_cmd_engine u_engine1 (
    .bus_clock_i(bus_clock_i),
    .arst_n_i   (arst_n_i),
    .out_valid_i(out_valid_i[1]),
    .out_beat_i (out_beat_i[1]),
    .out_ready_o(out_ready_o[1]),
    .in_valid_o (in_valid_o[1]),
    .in_beat_o  (in_beat_o[1]),
    .in_ready_i (in_ready_i[1]),
    .mem_req_o  (mem_req[1]),
    .mem_cmd_o  (mem_cmd[1]),
    .mem_ack_i  (mem_ack[1]),
    .mem_rdata_i(mem_rdata)
  );

  mem_arbiter u_arbiter (
    .bus_clock_i (bus_clock_i),
    .arst_n_i    (arst_n_i),
    .req_i       (mem_req),
    .cmd_i       (mem_cmd),
    .ack_o       (mem_ack),
    .rdata_o     (mem_rdata),
    .bank_en_o   (bank_en),
    .bank_cmd_o  (bank_cmd),
    .bank_rdata_i(bank_rdata)
  );

  sram_bank u_bank (
    .bus_clock_i(bus_clock_i),
    .en_i       (bank_en),
    .cmd_i      (bank_cmd),
    .rdata_o    (bank_rdata)
  );

endmodule

// File: tests/tb_stream_tasks.svh
// Send one packet on OUT stream ch, tlast on the final byte
task automatic send_packet(input int ch, input byte_t data[$]);
  for (int i = 0; i < data.size(); i++) begin
    @(posedge bus_clock);
    out_valid[ch] <= 1'b1;
    out_beat[ch]  <= {(i == data.size() - 1), data[i]};
    do @(negedge bus_clock); while (!out_ready[ch]);  // Transfer at the next edge
  end
  @(posedge bus_clock);
  out_valid[ch] <= 1'b0;
  // Engine is done with the packet once it takes OUT beats again
  do @(negedge bus_clock); while (!out_ready[ch]);
endtask

// Collect one IN packet on channel ch with random gaps on ready
task automatic recv_packet(input int ch, output byte_t data[$]);
  logic done;
  done = 1'b0;
  data = {};
  while (!done) begin
    @(posedge bus_clock);
    in_ready[ch] <= ($urandom_range(3) != 0);  // Low about one cycle in four
    @(negedge bus_clock);
    if (in_valid[ch] && in_ready[ch]) begin
      data.push_back(in_beat[ch].tdata);
      done = in_beat[ch].tlast;
    end
  end
  @(posedge bus_clock);
  in_ready[ch] <= 1'b1;  // Stray beats are still taken and counted
endtask

// File: tests/tb_mem_stream.sv
module tb_mem_stream;
  import mem_stream_pkg::*;

  typedef struct packed {
    logic        ch;
    byte_t       cmd;
    logic [15:0] addr;  // Bits above ADDR_W are dropped by the DUT
    len_t        len;   // Payload or read byte count minus one
    byte_t       seed;
    logic        par;   // Runs together with the next entry
  } entry_t;

  localparam int N_ENTRIES = 11;

  logic               bus_clock;
  logic               arst_n;
  logic [1:0]         out_valid;
  stream_beat_t [1:0] out_beat;
  logic [1:0]         out_ready;
  logic [1:0]         in_valid;
  stream_beat_t [1:0] in_beat;
  logic [1:0]         in_ready;

  entry_t tbl [N_ENTRIES];
  byte_t  model [MEM_DEPTH];
  int     beats_seen [2];
  int     beats_exp [2];
  int     value_errs;
  int     other_errs;
  int     cycles;
  int     limit;

  mem_stream_top uut (
    .bus_clock_i(bus_clock),
    .arst_n_i   (arst_n),
    .out_valid_i(out_valid),
    .out_beat_i (out_beat),
    .out_ready_o(out_ready),
    .in_valid_o (in_valid),
    .in_beat_o  (in_beat),
    .in_ready_i (in_ready)
  );

  `include "tb_stream_tasks.svh"

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic run_entry(input entry_t e);
    byte_t pkt[$];
    byte_t resp[$];
    int    a;
    a = int'(e.addr[ADDR_W-1:0]);
    pkt = {e.cmd, e.addr[15:8], e.addr[7:0]};
    if (e.cmd == CMD_READ) begin
      pkt.push_back(e.len);
      beats_exp[e.ch] += int'(e.len) + 1;
      fork
        send_packet(e.ch, pkt);
        recv_packet(e.ch, resp);
      join
      check_value("read beat count", resp.size(), int'(e.len) + 1);
      for (int n = 0; n < resp.size() && n <= int'(e.len); n++) begin
        check_value("read byte", resp[n], model[(a + n) % MEM_DEPTH]);
      end
    end else begin
      for (int n = 0; n <= int'(e.len); n++) begin
        pkt.push_back(byte_t'(int'(e.seed) + n * 13));
      end
      send_packet(e.ch, pkt);
      if (e.cmd == CMD_WRITE) begin
        for (int n = 0; n <= int'(e.len); n++) begin
          model[(a + n) % MEM_DEPTH] = pkt[n + 3];  // Same wrap rule as the buffer
        end
      end
    end
  endtask

  initial begin
    bus_clock = 1'b0;
    forever #10 bus_clock = ~bus_clock;
  end

  // Every accepted IN beat, so missing or extra responses show up
  always @(negedge bus_clock) begin
    for (int c = 0; c < 2; c++) begin
      if (in_valid[c] && in_ready[c]) beats_seen[c]++;
    end
  end

  always @(posedge bus_clock) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Errors: %0d value, %0d other", value_errs, other_errs);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int i;
    int total;
    void'($urandom(29866));
    arst_n = 1'b0;
    out_valid = '0;
    out_beat = '0;
    in_ready = 2'b11;
    value_errs = 0;
    other_errs = 0;
    cycles = 0;
    limit = 0;
    beats_seen = '{0, 0};
    beats_exp = '{0, 0};
    tbl[0]  = '{1'b0, CMD_WRITE, 16'h0010, 8'd7, 8'h11, 1'b0};
    tbl[1]  = '{1'b0, CMD_READ, 16'h0010, 8'd7, 8'h00, 1'b0};
    tbl[2]  = '{1'b1, CMD_READ, 16'h0010, 8'd7, 8'h00, 1'b0};  // Shared buffer
    tbl[3]  = '{1'b0, CMD_WRITE, 16'h0040, 8'd63, 8'h20, 1'b1};
    tbl[4]  = '{1'b1, CMD_WRITE, 16'h0100, 8'd63, 8'h80, 1'b0};
    tbl[5]  = '{1'b0, CMD_READ, 16'h0040, 8'd63, 8'h00, 1'b1};
    tbl[6]  = '{1'b1, CMD_READ, 16'h0100, 8'd63, 8'h00, 1'b0};
    tbl[7]  = '{1'b1, 8'h5A, 16'h0040, 8'd2, 8'h33, 1'b0};       // Unknown command
    tbl[8]  = '{1'b1, CMD_READ, 16'h0040, 8'd3, 8'h00, 1'b0};
    tbl[9]  = '{1'b0, CMD_WRITE, 16'h03FC, 8'd7, 8'hC0, 1'b0};   // Wraps past the top
    tbl[10] = '{1'b0, CMD_READ, 16'h01FE, 8'd5, 8'h00, 1'b0};
    total = 0;
    for (int k = 0; k < N_ENTRIES; k++) begin
      total += (tbl[k].cmd == CMD_READ) ? 4 + 2 * (int'(tbl[k].len) + 1) : 4 + int'(tbl[k].len);
    end
    limit = total * 16 + 500;
    repeat (3) @(posedge bus_clock);
    arst_n <= 1'b1;
    i = 0;
    while (i < N_ENTRIES) begin
      if (tbl[i].par && i + 1 < N_ENTRIES) begin
        fork
          run_entry(tbl[i]);
          run_entry(tbl[i + 1]);
        join
        i += 2;
      end else begin
        run_entry(tbl[i]);
        i += 1;
      end
    end
    repeat (20) @(posedge bus_clock);
    for (int c = 0; c < 2; c++) begin
      if (beats_seen[c] != beats_exp[c]) begin
        other_errs++;
        $display("Channel %0d sent %0d IN beats, expected %0d, a response is missing or extra",
                 c, beats_seen[c], beats_exp[c]);
      end
    end
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+tests
design/mem_stream_pkg.sv
design/sram_bank.sv
design/mem_arbiter.sv
design/stream_cmd_engine.sv
design/mem_stream_top.sv
tests/tb_mem_stream.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_mem_stream -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0
